// ==== Bender.yml ====
package:
  name: foc_current_loop

sources:
  - include_dirs:
      - design
    files:
      - design/foc_pkg.sv
      - design/skid_buffer.sv
      - design/cordic_sincos.sv
      - design/clarke_xform.sv
      - design/park_xform.sv
      - design/pi_regulator.sv
      - design/foc_current_loop.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/clk_gen.sv
      - dv/foc_properties.sv
      - dv/foc_tb.sv

// ==== design/clarke_xform.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module clarke_xform import foc_pkg::*; (
  input  logic               clk,
  input  logic               rstb,
  input  logic               start_i,
  input  logic signed [15:0] ia_i,
  input  logic signed [15:0] ib_i,
  output logic               done_o,
  output foc_ab_t            ab_o
);

  localparam int DW = `FOC_DW;
  localparam logic signed [16:0] INV_SQRT3 = 17'sd18919;  // Q15

  logic signed [DW-1:0] sum_ab;
  logic signed [DW+16:0] beta_prod;

  // ic is implied, so beta = (ia + 2*ib)/sqrt3
  assign sum_ab    = DW'(ia_i) + (DW'(ib_i) <<< 1);
  assign beta_prod = sum_ab * INV_SQRT3;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      done_o <= 1'b0;
    end else if (start_i) begin
      done_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      ab_o <= '{alpha: DW'(ia_i), beta: DW'(beta_prod >>> `FOC_QB)};
    end
  end

endmodule

// ==== design/cordic_sincos.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module cordic_sincos import foc_pkg::*; (
  input  logic        clk,
  input  logic        rstb,
  input  logic        start_i,
  input  logic [15:0] angle_i,
  output logic        done_o,
  output foc_sc_t     sc_o
);

  localparam int IW = $clog2(`FOC_ITER);
  localparam int XW = 20;  // x/y in Q17
  localparam int ZW = 20;  // quarter turn is 2^18
  localparam logic signed [XW-1:0] X_INIT = 20'sd79594;  // 1/gain in Q17

  logic signed [XW-1:0] x_q;
  logic signed [XW-1:0] y_q;
  logic signed [ZW-1:0] z_q;
  logic signed [XW-1:0] x_nx;
  logic signed [XW-1:0] y_nx;
  logic signed [ZW-1:0] z_nx;
  logic [1:0]           quad_q;
  logic [IW-1:0]        iter_q;
  logic                 busy_q;
  logic                 last_iter;
  foc_sc_t              sc_nx;

  // atan(2^-i) scaled to 2^18 per quarter turn
  function automatic logic signed [ZW-1:0] atan_lut(input logic [IW-1:0] idx);
    case (idx)
      0:  atan_lut = 131072;
      1:  atan_lut = 77376;
      2:  atan_lut = 40884;
      3:  atan_lut = 20753;
      4:  atan_lut = 10417;
      5:  atan_lut = 5213;
      6:  atan_lut = 2607;
      7:  atan_lut = 1304;
      8:  atan_lut = 652;
      9:  atan_lut = 326;
      10: atan_lut = 163;
      11: atan_lut = 81;
      12: atan_lut = 41;
      13: atan_lut = 20;
      14: atan_lut = 10;
      15: atan_lut = 5;
      default: atan_lut = '0;
    endcase
  endfunction

  // round Q17 down to Q15, clamp at full scale
  function automatic logic signed [15:0] to_q15(input logic signed [XW-1:0] v);
    logic signed [XW-1:0] r;
    r = (v + 2) >>> 2;
    if (r > 32767) to_q15 = 16'sh7fff;
    else if (r < -32768) to_q15 = 16'sh8000;
    else to_q15 = r[15:0];
  endfunction

  assign last_iter = busy_q && (iter_q == IW'(`FOC_ITER - 1));

  always_comb begin
    if (z_q[ZW-1]) begin
      x_nx = x_q + (y_q >>> iter_q);
      y_nx = y_q - (x_q >>> iter_q);
      z_nx = z_q + atan_lut(iter_q);
    end else begin
      x_nx = x_q - (y_q >>> iter_q);
      y_nx = y_q + (x_q >>> iter_q);
      z_nx = z_q - atan_lut(iter_q);
    end
  end

  // put the folded quadrant back
  always_comb begin
    case (quad_q)
      2'd0:    sc_nx = '{sin: to_q15(y_nx), cos: to_q15(x_nx)};
      2'd1:    sc_nx = '{sin: to_q15(x_nx), cos: to_q15(-y_nx)};
      2'd2:    sc_nx = '{sin: to_q15(-y_nx), cos: to_q15(-x_nx)};
      default: sc_nx = '{sin: to_q15(-x_nx), cos: to_q15(y_nx)};
    endcase
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      busy_q <= 1'b0;
      iter_q <= '0;
      done_o <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      iter_q <= '0;
      done_o <= 1'b0;
    end else if (busy_q) begin
      iter_q <= iter_q + 1'b1;
      if (last_iter) begin
        busy_q <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      x_q    <= X_INIT;
      y_q    <= '0;
      z_q    <= ZW'({angle_i[13:0], 4'b0000});  // residual within the quadrant
      quad_q <= angle_i[15:14];
    end else if (busy_q) begin
      x_q <= x_nx;
      y_q <= y_nx;
      z_q <= z_nx;
      if (last_iter) begin
        sc_o <= sc_nx;
      end
    end
  end

endmodule

// ==== design/foc_current_loop.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module foc_current_loop import foc_pkg::*; (
  input  logic          clk,
  input  logic          rstb,
  input  logic          s_valid_i,
  output logic          s_ready_o,
  input  foc_sample_t   s_data_i,
  output logic          m_valid_o,
  input  logic          m_ready_i,
  output foc_result_t   m_data_o,
  input  foc_gain_cfg_t gain_cfg_i
);

  localparam int DW = `FOC_DW;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FRONT,
    S_PARK,
    S_REG,
    S_PUSH
  } seq_state_e;

  seq_state_e           state_q;
  logic                 front_start_q;
  foc_sample_t          smp_q;
  logic signed [DW-1:0] iq_tgt_q;

  logic        smp_valid;
  logic        smp_ready;
  foc_sample_t smp_data;
  logic        res_valid;
  logic        res_ready;
  foc_result_t res_data;

  logic                 cordic_done;
  logic                 clarke_done;
  logic                 park_start;
  logic                 park_done;
  logic                 pi_iterate;
  logic                 pi_d_done;
  logic                 pi_q_done;
  foc_sc_t              sc;
  foc_ab_t              ab;
  foc_dq_t              dq;
  logic signed [DW-1:0] vd;
  logic signed [DW-1:0] vq;

  skid_buffer #(.T(foc_sample_t)) i_in_buf (
    .clk         (clk),
    .rstb        (rstb),
    .in_valid_i  (s_valid_i),
    .in_ready_o  (s_ready_o),
    .in_data_i   (s_data_i),
    .out_valid_o (smp_valid),
    .out_ready_i (smp_ready),
    .out_data_o  (smp_data)
  );

  // only idle pops the input
  assign smp_ready = (state_q == S_IDLE);

  // done flags are stale while the start pulse is still out
  assign park_start = (state_q == S_FRONT) && !front_start_q && cordic_done && clarke_done;
  assign pi_iterate = (state_q == S_PARK) && park_done;
  assign res_valid  = ((state_q == S_REG) && pi_d_done && pi_q_done) || (state_q == S_PUSH);
  assign res_data   = '{id: dq.d, iq: dq.q, vd: vd, vq: vq};

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state_q       <= S_IDLE;
      front_start_q <= 1'b0;
    end else begin
      front_start_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (smp_valid) begin
            front_start_q <= 1'b1;
            state_q       <= S_FRONT;
          end
        end
        S_FRONT: if (park_start) state_q <= S_PARK;
        S_PARK:  if (pi_iterate) state_q <= S_REG;
        S_REG: begin
          if (res_valid) begin
            state_q <= res_ready ? S_IDLE : S_PUSH;  // hold result on back-pressure
          end
        end
        S_PUSH:  if (res_ready) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && smp_valid) begin
      smp_q    <= smp_data;
      iq_tgt_q <= DW'(smp_data.iq_target);
    end
  end

  cordic_sincos i_cordic (
    .clk     (clk),
    .rstb    (rstb),
    .start_i (front_start_q),
    .angle_i (smp_q.angle),
    .done_o  (cordic_done),
    .sc_o    (sc)
  );

  clarke_xform i_clarke (
    .clk     (clk),
    .rstb    (rstb),
    .start_i (front_start_q),
    .ia_i    (smp_q.ia),
    .ib_i    (smp_q.ib),
    .done_o  (clarke_done),
    .ab_o    (ab)
  );

  park_xform i_park (
    .clk     (clk),
    .rstb    (rstb),
    .start_i (park_start),
    .ab_i    (ab),
    .sc_i    (sc),
    .done_o  (park_done),
    .dq_o    (dq)
  );

  // d target is zero
  pi_regulator #(.AXIS(1'b0)) i_pi_d (
    .clk       (clk),
    .rstb      (rstb),
    .cfg_i     (gain_cfg_i),
    .iterate_i (pi_iterate),
    .target_i  ('0),
    .meas_i    (dq.d),
    .done_o    (pi_d_done),
    .out_o     (vd)
  );

  pi_regulator #(.AXIS(1'b1)) i_pi_q (
    .clk       (clk),
    .rstb      (rstb),
    .cfg_i     (gain_cfg_i),
    .iterate_i (pi_iterate),
    .target_i  (iq_tgt_q),
    .meas_i    (dq.q),
    .done_o    (pi_q_done),
    .out_o     (vq)
  );

  skid_buffer #(.T(foc_result_t)) i_out_buf (
    .clk         (clk),
    .rstb        (rstb),
    .in_valid_i  (res_valid),
    .in_ready_o  (res_ready),
    .in_data_i   (res_data),
    .out_valid_o (m_valid_o),
    .out_ready_i (m_ready_i),
    .out_data_o  (m_data_o)
  );

endmodule

// ==== design/foc_params.svh ====
`ifndef FOC_PARAMS_SVH
`define FOC_PARAMS_SVH

// datapath width, 16-bit currents sign-extend into it
`define FOC_DW   18

`define FOC_QB   15   // fraction bits of sin/cos and gains
`define FOC_ITER 16   // cordic micro-rotations

// clamp for integrator and regulator output
`define FOC_LIM  4096

`endif

// ==== design/foc_pkg.sv ====
`include "foc_params.svh"

package foc_pkg;

  // one resolver/current sample from the input port
  typedef struct packed {
    logic        [15:0] angle;      // full turn is 2^16
    logic signed [15:0] ia;
    logic signed [15:0] ib;
    logic signed [15:0] iq_target;
  } foc_sample_t;

  typedef struct packed {
    logic signed [`FOC_DW-1:0] id;
    logic signed [`FOC_DW-1:0] iq;
    logic signed [`FOC_DW-1:0] vd;
    logic signed [`FOC_DW-1:0] vq;
  } foc_result_t;

  typedef struct packed {
    logic signed [`FOC_DW-1:0] alpha;
    logic signed [`FOC_DW-1:0] beta;
  } foc_ab_t;

  // Q15
  typedef struct packed {
    logic signed [15:0] sin;
    logic signed [15:0] cos;
  } foc_sc_t;

  typedef struct packed {
    logic signed [`FOC_DW-1:0] d;
    logic signed [`FOC_DW-1:0] q;
  } foc_dq_t;

  typedef struct packed {
    logic        wen;
    logic        axis;  // 0 selects d, 1 selects q
    logic [15:0] kp;    // unsigned Q15
    logic [15:0] ki;
  } foc_gain_cfg_t;

endpackage

// ==== design/park_xform.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module park_xform import foc_pkg::*; (
  input  logic    clk,
  input  logic    rstb,
  input  logic    start_i,
  input  foc_ab_t ab_i,
  input  foc_sc_t sc_i,
  output logic    done_o,
  output foc_dq_t dq_o
);

  localparam int DW = `FOC_DW;
  localparam int PW = DW + 16;

  logic signed [PW-1:0] ac_q;
  logic signed [PW-1:0] bs_q;
  logic signed [PW-1:0] bc_q;
  logic signed [PW-1:0] as_q;
  logic signed [PW:0]   d_sum;
  logic signed [PW:0]   q_sum;
  logic                 stage_q;

  assign d_sum = ac_q + bs_q;
  assign q_sum = bc_q - as_q;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      stage_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      stage_q <= start_i;
      if (start_i) begin
        done_o <= 1'b0;
      end else if (stage_q) begin
        done_o <= 1'b1;
      end
    end
  end

  // products first, sums second
  always_ff @(posedge clk) begin
    if (start_i) begin
      ac_q <= ab_i.alpha * sc_i.cos;
      bs_q <= ab_i.beta * sc_i.sin;
      bc_q <= ab_i.beta * sc_i.cos;
      as_q <= ab_i.alpha * sc_i.sin;
    end
    if (stage_q) begin
      dq_o <= '{d: DW'(d_sum >>> `FOC_QB), q: DW'(q_sum >>> `FOC_QB)};
    end
  end

endmodule

// ==== design/pi_regulator.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module pi_regulator import foc_pkg::*; #(
  parameter bit AXIS = 1'b0
) (
  input  logic                      clk,
  input  logic                      rstb,
  input  foc_gain_cfg_t             cfg_i,
  input  logic                      iterate_i,
  input  logic signed [`FOC_DW-1:0] target_i,
  input  logic signed [`FOC_DW-1:0] meas_i,
  output logic                      done_o,
  output logic signed [`FOC_DW-1:0] out_o
);

  localparam int DW = `FOC_DW;
  localparam int EW = DW + 1;
  localparam int PW = EW + 17;  // error times zero-extended gain
  localparam int SW = PW + 1;

  logic [15:0]          kp_q;
  logic [15:0]          ki_q;
  logic signed [EW-1:0] err;
  logic signed [PW-1:0] p_prod;
  logic signed [PW-1:0] i_prod;
  logic signed [PW-1:0] p_term_q;
  logic signed [PW-1:0] i_term_q;
  logic signed [SW-1:0] integ_sum;
  logic signed [SW-1:0] out_sum;
  logic signed [DW-1:0] integ_q;
  logic signed [DW-1:0] integ_nx;
  logic                 stage_q;

  function automatic logic signed [DW-1:0] clamp(input logic signed [SW-1:0] v);
    if (v > `FOC_LIM) clamp = DW'(`FOC_LIM);
    else if (v < -`FOC_LIM) clamp = -DW'(`FOC_LIM);
    else clamp = v[DW-1:0];
  endfunction

  assign err    = EW'(target_i) - EW'(meas_i);
  assign p_prod = err * $signed({1'b0, kp_q});
  assign i_prod = err * $signed({1'b0, ki_q});

  // output uses the freshly updated integrator
  assign integ_sum = SW'(integ_q) + SW'(i_term_q);
  assign integ_nx  = clamp(integ_sum);
  assign out_sum   = SW'(p_term_q) + SW'(integ_nx);

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      kp_q    <= '0;
      ki_q    <= '0;
      integ_q <= '0;
      stage_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      if (cfg_i.wen && cfg_i.axis == AXIS) begin
        kp_q <= cfg_i.kp;
        ki_q <= cfg_i.ki;
      end
      stage_q <= iterate_i;
      if (iterate_i) begin
        done_o <= 1'b0;
      end else if (stage_q) begin
        done_o  <= 1'b1;
        integ_q <= integ_nx;
      end
    end
  end

  // gains sampled here, so a write lands on the next iterate
  always_ff @(posedge clk) begin
    if (iterate_i) begin
      p_term_q <= p_prod >>> `FOC_QB;
      i_term_q <= i_prod >>> `FOC_QB;
    end
    if (stage_q) begin
      out_o <= clamp(out_sum);
    end
  end

endmodule

// ==== design/skid_buffer.sv ====
`timescale 1ns/100ps

module skid_buffer #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic rstb,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  logic out_valid_q;
  logic skid_valid_q;
  T     out_data_q;
  T     skid_data_q;
  logic in_fire;
  logic out_free;

  // ready only looks at local state
  assign in_ready_o = ~skid_valid_q;
  assign in_fire    = in_valid_i & ~skid_valid_q;
  assign out_free   = out_ready_i | ~out_valid_q;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      out_valid_q  <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;  // head stalled, park new entry
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data_q <= skid_valid_q ? skid_data_q : in_data_i;  // older entry first
    end
    if (in_fire && !out_free) begin
      skid_data_q <= in_data_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
  parameter real PERIOD_NS  = 10.0,
  parameter int  RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rstb_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rstb_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rstb_o = 1'b1;
  end

endmodule

// ==== dv/foc_properties.sv ====
`timescale 1ns/100ps

module foc_properties import foc_pkg::*; (
  input logic        clk,
  input logic        rstb,
  input logic        s_valid_i,
  input logic        s_ready_i,
  input foc_sample_t s_data_i,
  input logic        m_valid_i,
  input logic        m_ready_i,
  input foc_result_t m_data_i
);

  int          assert_fails = 0;
  int unsigned in_cnt;
  int unsigned out_cnt;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      in_cnt  <= 0;
      out_cnt <= 0;
    end else begin
      if (s_valid_i && s_ready_i) in_cnt <= in_cnt + 1;
      if (m_valid_i && m_ready_i) out_cnt <= out_cnt + 1;
    end
  end

  a_s_hold: assert property (@(posedge clk) disable iff (!rstb)
    s_valid_i && !s_ready_i |=> s_valid_i && $stable(s_data_i))
  else begin
    assert_fails++;
    $error("input valid or data changed before ready");
  end

  a_m_hold: assert property (@(posedge clk) disable iff (!rstb)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i))
  else begin
    assert_fails++;
    $error("output valid or data changed before ready");
  end

  a_m_reset: assert property (@(posedge clk) !rstb |-> !m_valid_i)
  else begin
    assert_fails++;
    $error("m_valid_o high during reset");
  end

  // no result without an accepted sample ahead of it
  a_order: assert property (@(posedge clk) disable iff (!rstb)
    m_valid_i |-> out_cnt < in_cnt)
  else begin
    assert_fails++;
    $error("output valid without an earlier input");
  end

endmodule

bind foc_current_loop foc_properties i_props (
  .clk       (clk),
  .rstb      (rstb),
  .s_valid_i (s_valid_i),
  .s_ready_i (s_ready_o),
  .s_data_i  (s_data_i),
  .m_valid_i (m_valid_o),
  .m_ready_i (m_ready_i),
  .m_data_i  (m_data_o)
);

// ==== dv/foc_tb.sv ====
`timescale 1ns/100ps
`include "foc_params.svh"

module foc_tb import foc_pkg::*; ();

  localparam int  SEED      = 39375;
  localparam int  N_SAMPLES = 186;
  localparam int  WD_CYCLES = N_SAMPLES * 60 + 2000;
  localparam real LIM       = `FOC_LIM;
  localparam real PI        = 3.14159265358979;

  logic          clk;
  logic          rstb;
  logic          s_valid;
  logic          s_ready;
  foc_sample_t   s_data;
  logic          m_valid;
  logic          m_ready;
  foc_result_t   m_data;
  foc_gain_cfg_t gain_cfg;

  int  ready_pct = 100;
  int  errors    = 0;
  int  n_checked = 0;
  int  err_mark  = 0;
  int  chk_mark  = 0;
  bit  saw_stall;
  real integ_m[2];
  real drift_m[2];
  int  kp_m[2];
  int  ki_m[2];
  real eid_q[$];
  real eiq_q[$];
  real evd_q[$];
  real evq_q[$];
  real tvd_q[$];
  real tvq_q[$];
  logic signed [`FOC_DW-1:0] last_vd;
  logic signed [`FOC_DW-1:0] last_vq;
  int sweep_angles[12] = '{0, 1, 16383, 16384, 16385, 32767, 32768, 32769,
                           49151, 49152, 49153, 65535};

  clk_gen #(.PERIOD_NS(10.0), .RST_CYCLES(3)) i_clk_gen (.clk_o(clk), .rstb_o(rstb));

  foc_current_loop i_foc_current_loop (
    .clk        (clk),
    .rstb       (rstb),
    .s_valid_i  (s_valid),
    .s_ready_o  (s_ready),
    .s_data_i   (s_data),
    .m_valid_o  (m_valid),
    .m_ready_i  (m_ready),
    .m_data_o   (m_data),
    .gain_cfg_i (gain_cfg)
  );

  function automatic real clip(input real v);
    if (v > LIM) return LIM;
    if (v < -LIM) return -LIM;
    return v;
  endfunction

  function automatic int rand_signed(input int m);
    return int'($urandom_range(2 * m)) - m;
  endfunction

  function automatic foc_sample_t make_sample(input int angle, input int ia, input int ib,
                                              input int iqt);
    foc_sample_t s;
    s.angle     = angle[15:0];
    s.ia        = ia[15:0];
    s.ib        = ib[15:0];
    s.iq_target = iqt[15:0];
    return s;
  endfunction

  function automatic foc_sample_t rand_sample(input int m);
    return make_sample($urandom_range(65535), rand_signed(m), rand_signed(m), rand_signed(m));
  endfunction

  // drift bounds how far the integrator may have wandered from the real one
  task automatic pi_step(input int ax, input real err, output real v, output real tol);
    real isum;
    real osum;
    isum = integ_m[ax] + ki_m[ax] * err / 32768.0;
    if (ki_m[ax] != 0) drift_m[ax] += 4.0 + 8.0 * ki_m[ax] / 32768.0;
    if (isum > LIM + drift_m[ax] || isum < -(LIM + drift_m[ax])) drift_m[ax] = 0.0;  // both clamp
    integ_m[ax] = clip(isum);
    tol = drift_m[ax] + ((kp_m[ax] != 0) ? 8.0 * kp_m[ax] / 32768.0 + 1.0 : 0.0);
    osum = kp_m[ax] * err / 32768.0 + integ_m[ax];
    v = clip(osum);
    if (osum > LIM + tol || osum < -(LIM + tol)) tol = 0.0;  // saturated, must be exact
  endtask

  task automatic predict(input foc_sample_t s);
    real th;
    real al;
    real be;
    real d;
    real q;
    real vd;
    real vq;
    real td;
    real tq;
    th = 2.0 * PI * s.angle / 65536.0;
    al = s.ia;
    be = (s.ia + 2.0 * s.ib) / $sqrt(3.0);
    d  = al * $cos(th) + be * $sin(th);
    q  = be * $cos(th) - al * $sin(th);
    pi_step(0, 0.0 - d, vd, td);
    pi_step(1, s.iq_target - q, vq, tq);
    eid_q.push_back(d);
    eiq_q.push_back(q);
    evd_q.push_back(vd);
    evq_q.push_back(vq);
    tvd_q.push_back(td);
    tvq_q.push_back(tq);
  endtask

  task automatic check_val(input string name, input logic signed [`FOC_DW-1:0] got,
                           input real want, input real tol);
    real g;
    logic [`FOC_DW-1:0] want_bits;
    g = got;
    if (g - want > tol || want - g > tol) begin
      want_bits = $rtoi(want + (want < 0.0 ? -0.5 : 0.5));
      $display("[ERROR] %s got 0x%05h expected 0x%05h", name, got, want_bits);
      errors++;
    end
  endtask

  task automatic check_output();
    if (eid_q.size() == 0) begin
      errors++;
      $display("a result came out with no sample pending");
    end else begin
      check_val("m_data_o.id", m_data.id, eid_q.pop_front(), 8.0);
      check_val("m_data_o.iq", m_data.iq, eiq_q.pop_front(), 8.0);
      check_val("m_data_o.vd", m_data.vd, evd_q.pop_front(), tvd_q.pop_front());
      check_val("m_data_o.vq", m_data.vq, evq_q.pop_front(), tvq_q.pop_front());
      n_checked++;
    end
    last_vd = m_data.vd;
    last_vq = m_data.vq;
  endtask

  // enters and leaves on a falling edge
  task automatic send_sample(input foc_sample_t s);
    s_data  = s;
    s_valid = 1'b1;
    while (!s_ready) @(negedge clk);
    predict(s);
    @(negedge clk);
    s_valid = 1'b0;
  endtask

  task automatic write_gain(input bit ax, input int kp, input int ki);
    gain_cfg = '{wen: 1'b1, axis: ax, kp: kp[15:0], ki: ki[15:0]};
    kp_m[ax] = kp;
    ki_m[ax] = ki;
    @(negedge clk);
    gain_cfg.wen = 1'b0;
  endtask

  task automatic wait_drain();
    while (eid_q.size() != 0) @(negedge clk);
  endtask

  task automatic set_ready_pct(input int pct);
    @(posedge clk);
    ready_pct = pct;
    @(negedge clk);
  endtask

  task automatic end_test(input int num, input string name);
    wait_drain();
    $display("test %0d %s: %0d results, %0d errors", num, name, n_checked - chk_mark,
             errors - err_mark);
    err_mark = errors;
    chk_mark = n_checked;
  endtask

  // output side runs on the falling edge too
  always @(negedge clk) begin
    m_ready = ($urandom_range(99) < ready_pct);
    if (rstb && !s_ready) saw_stall = 1'b1;
    if (m_valid && m_ready) check_output();
  end

  initial begin
    s_valid  = 1'b0;
    s_data   = '0;
    m_ready  = 1'b0;
    gain_cfg = '0;
    void'($urandom(SEED));
    for (int ax = 0; ax < 2; ax++) begin
      integ_m[ax] = 0.0;
      drift_m[ax] = 0.0;
      kp_m[ax]    = 0;
      ki_m[ax]    = 0;
    end
    @(posedge rstb);
    @(negedge clk);

    repeat (40) send_sample(rand_sample(16000));
    end_test(1, "zero gains");

    foreach (sweep_angles[i]) begin
      send_sample(make_sample(sweep_angles[i], rand_signed(16000), rand_signed(16000), 0));
    end
    for (int k = 0; k < 8; k++) begin
      send_sample(make_sample((k % 4) * 16384 + int'($urandom_range(16383)),
                              rand_signed(16000), rand_signed(16000), 0));
    end
    end_test(2, "angle sweep");

    write_gain(1'b0, 8192, 0);
    write_gain(1'b1, 16384, 0);
    repeat (30) send_sample(rand_sample(4000));
    end_test(3, "proportional only");

    // large constant error, d and q pushed to opposite rails
    write_gain(1'b0, 0, 2048);
    write_gain(1'b1, 0, 2048);
    repeat (12) send_sample(make_sample(0, 20000, -10000, 20000));
    wait_drain();
    check_val("m_data_o.vd", last_vd, -LIM, 0.0);
    check_val("m_data_o.vq", last_vq, LIM, 0.0);
    repeat (12) send_sample(make_sample(0, -20000, 10000, -20000));
    wait_drain();
    check_val("m_data_o.vd", last_vd, LIM, 0.0);
    check_val("m_data_o.vq", last_vq, -LIM, 0.0);
    end_test(4, "integral saturation");

    write_gain(1'b0, 4096, 0);
    write_gain(1'b1, 4096, 0);
    @(posedge clk);
    saw_stall = 1'b0;
    ready_pct = 0;
    @(negedge clk);
    fork
      repeat (12) send_sample(rand_sample(12000));
      begin
        repeat (150) @(negedge clk);
        @(posedge clk);
        ready_pct = 50;
      end
    join
    for (int k = 0; k < 40; k++) begin
      send_sample(rand_sample(12000));
      repeat ($urandom_range(3)) @(negedge clk);
    end
    set_ready_pct(100);
    if (!saw_stall) begin
      errors++;
      $display("s_ready_o never dropped while the output was stalled");
    end
    end_test(5, "back-pressure");

    write_gain(1'b1, 24576, 0);  // q only
    repeat (20) send_sample(rand_sample(8000));
    end_test(6, "per-axis gain write");

    $display("6 tests, %0d results checked, %0d errors, %0d assertion failures", n_checked,
             errors, i_foc_current_loop.i_props.assert_fails);
    if (errors == 0 && i_foc_current_loop.i_props.assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WD_CYCLES * 10);
    $display("watchdog expired after %0d cycles with %0d results pending", WD_CYCLES,
             eid_q.size());
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/foc_pkg.sv
design/skid_buffer.sv
design/cordic_sincos.sv
design/clarke_xform.sv
design/park_xform.sv
design/pi_regulator.sv
design/foc_current_loop.sv
dv/clk_gen.sv
dv/foc_properties.sv
dv/foc_tb.sv
